// File: include/midi_sysex_consts.svh
`ifndef MIDI_SYSEX_CONSTS_SVH
`define MIDI_SYSEX_CONSTS_SVH

// protocol bytes
`define MS_SOX              8'hF0
`define MS_EOX              8'hF7
`define MS_EDU_ID           8'h7D

// command nibbles, high half of frame byte 2
`define MS_CMD_CTRL         4'h1
`define MS_CMD_BANK         4'h2
`define MS_CMD_DUMP         4'h3
`define MS_CMD_PATCH        4'h7

// patch memory geometry
`define MS_BANK_WORDS       8'd64
`define MS_LAST_BANK_WORDS  8'd32
`define MS_PATCH_BYTES      8'd224
`define MS_DUMP_BANK_3RD    3'd5

`endif

// File: src/midi_sysex_pkg.sv
package midi_sysex_pkg;

    typedef struct packed {
        logic [7:0] data;
        logic [7:0] index;      // position in frame, saturates at 255
        logic       in_sysex;
    } midi_byte_t;

    typedef struct packed {
        logic [2:0] bank;
        logic [6:0] offset;
    } patch_addr_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        patch_addr_t adr;
        logic [7:0]  dat;
    } wb_m2s_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_s2m_t;

endpackage

// File: src/midi_byte_framer.sv
`timescale 1ns/100ps
`include "midi_sysex_consts.svh"

module midi_byte_framer (
    input  logic                       clk,
    input  logic                       reset_reg_N,
    input  logic [7:0]                 rx_data,
    input  logic                       rx_valid,
    output midi_sysex_pkg::midi_byte_t byte_out,
    output logic                       byte_stb
);
    import midi_sysex_pkg::*;

    logic       in_frame;
    logic [7:0] byte_cnt;
    logic       is_rt;
    logic       is_sox;
    logic       is_eox;
    logic       is_data;

    assign is_rt   = rx_data >= 8'hF8;
    assign is_sox  = rx_data == `MS_SOX;
    assign is_eox  = rx_data == `MS_EOX;
    assign is_data = !rx_data[7];

    always_ff @(posedge clk) begin
        if (!reset_reg_N) begin
            in_frame <= 1'b0;
            byte_cnt <= 8'd0;
            byte_out <= '0;
            byte_stb <= 1'b0;
        end else begin
            byte_stb <= 1'b0;
            if (rx_valid && !is_rt) begin   // realtime bytes pass untouched
                if (is_sox) begin
                    in_frame <= 1'b1;
                    byte_cnt <= 8'd1;
                    byte_out <= '{data: rx_data, index: 8'd0, in_sysex: 1'b1};
                    byte_stb <= 1'b1;
                end else if (in_frame && (is_data || is_eox)) begin
                    byte_out <= '{data: rx_data, index: byte_cnt, in_sysex: 1'b1};
                    byte_stb <= 1'b1;
                    if (byte_cnt != 8'hFF) begin
                        byte_cnt <= byte_cnt + 8'd1;
                    end
                    if (is_eox) begin
                        in_frame <= 1'b0;
                    end
                end else if (!is_data) begin
                    in_frame          <= 1'b0;  // stray status aborts
                    byte_out.in_sysex <= 1'b0;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!reset_reg_N) rx_valid |=> !rx_valid)
        else $error("rx strobe held for more than one cycle");

endmodule

// File: src/sysex_decoder.sv
`timescale 1ns/100ps
`include "midi_sysex_consts.svh"

module sysex_decoder (
    input  logic                       clk,
    input  logic                       reset_reg_N,
    input  logic [3:0]                 midi_channel,
    input  midi_sysex_pkg::midi_byte_t byte_in,
    input  logic                       byte_stb,
    output midi_sysex_pkg::wb_m2s_t    wb_o,
    input  midi_sysex_pkg::wb_s2m_t    wb_i,
    output logic                       dump_req
);
    import midi_sysex_pkg::*;

    typedef enum logic [1:0] {M_IDLE, M_CTRL, M_BANK, M_PATCH} mode_t;

    localparam logic [7:0] BANK1_BASE = `MS_BANK_WORDS;
    localparam logic [7:0] BANK2_BASE = BANK1_BASE + `MS_BANK_WORDS;
    localparam logic [7:0] BANK5_BASE = BANK2_BASE + `MS_BANK_WORDS;

    mode_t       mode;
    logic        edu_id;
    patch_addr_t tgt_adr;       // ctrl target, bank load uses bank only
    logic [7:0]  tgt_dat;
    logic        wr_cyc;
    patch_addr_t wr_adr;
    logic [7:0]  wr_dat;
    logic        is_eox;
    logic [7:0]  bank_pos;
    logic [7:0]  patch_pos;
    logic [7:0]  bank_limit;
    logic [2:0]  patch_bank;
    logic [6:0]  patch_off;
    logic        do_write;
    patch_addr_t nxt_adr;
    logic [7:0]  nxt_dat;

    assign is_eox     = byte_in.data == `MS_EOX;
    assign bank_pos   = byte_in.index - 8'd4;
    assign patch_pos  = byte_in.index - 8'd3;
    assign bank_limit = (tgt_adr.bank == `MS_DUMP_BANK_3RD) ? `MS_LAST_BANK_WORDS
                                                           : `MS_BANK_WORDS;

    // patch load walks banks in dump order
    always_comb begin
        if (patch_pos < BANK1_BASE) begin
            patch_bank = 3'd0;
            patch_off  = 7'(patch_pos);
        end else if (patch_pos < BANK2_BASE) begin
            patch_bank = 3'd1;
            patch_off  = 7'(patch_pos - BANK1_BASE);
        end else if (patch_pos < BANK5_BASE) begin
            patch_bank = 3'd2;
            patch_off  = 7'(patch_pos - BANK2_BASE);
        end else begin
            patch_bank = `MS_DUMP_BANK_3RD;
            patch_off  = 7'(patch_pos - BANK5_BASE);
        end
    end

    always_comb begin
        do_write = 1'b0;
        nxt_adr  = tgt_adr;
        nxt_dat  = byte_in.data;
        case (mode)
            M_CTRL: begin
                do_write = byte_in.index == 8'd6 && is_eox;
                nxt_dat  = tgt_dat;
            end
            M_BANK: begin
                do_write       = byte_in.index >= 8'd4 && !is_eox && bank_pos < bank_limit;
                nxt_adr.offset = bank_pos[6:0];
            end
            M_PATCH: begin
                do_write = byte_in.index >= 8'd3 && !is_eox && patch_pos < `MS_PATCH_BYTES;
                nxt_adr  = '{bank: patch_bank, offset: patch_off};
            end
            default: do_write = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_reg_N) begin
            mode     <= M_IDLE;
            edu_id   <= 1'b0;
            wr_cyc   <= 1'b0;
            dump_req <= 1'b0;
        end else begin
            dump_req <= 1'b0;
            if (wr_cyc && wb_i.ack) begin
                wr_cyc <= 1'b0;
            end
            if (byte_stb) begin
                if (do_write) begin
                    wr_cyc <= 1'b1;
                    wr_adr <= nxt_adr;
                    wr_dat <= nxt_dat;
                end
                case (byte_in.index)
                    8'd0: begin
                        mode   <= M_IDLE;
                        edu_id <= 1'b0;
                    end
                    8'd1: edu_id <= byte_in.data == `MS_EDU_ID;
                    8'd2: if (edu_id && byte_in.data[3:0] == midi_channel) begin
                        case (byte_in.data[7:4])
                            `MS_CMD_CTRL:  mode <= M_CTRL;
                            `MS_CMD_BANK:  mode <= M_BANK;
                            `MS_CMD_DUMP:  dump_req <= 1'b1;
                            `MS_CMD_PATCH: mode <= M_PATCH;
                            default:       mode <= M_IDLE;
                        endcase
                    end
                    8'd3: tgt_adr.bank <= byte_in.data[2:0];
                    8'd4: tgt_adr.offset <= byte_in.data[6:0];
                    8'd5: tgt_dat <= byte_in.data;
                    default: ;
                endcase
                if (is_eox || (mode == M_CTRL && byte_in.index >= 8'd6)) begin
                    mode <= M_IDLE;         // end of frame or ctrl done
                end
            end else if (!byte_in.in_sysex) begin
                mode <= M_IDLE;             // framer saw an abort
            end
        end
    end

    assign wb_o = '{cyc: wr_cyc, stb: wr_cyc, we: wr_cyc, adr: wr_adr, dat: wr_dat};

    assert property (@(posedge clk) disable iff (!reset_reg_N) byte_stb |-> !wr_cyc)
        else $error("new byte while a write cycle is open");

endmodule

// File: src/patch_memory.sv
`timescale 1ns/100ps
`include "midi_sysex_consts.svh"

module patch_memory (
    input  logic                    clk,
    input  logic                    reset_reg_N,
    input  midi_sysex_pkg::wb_m2s_t wr_i,
    input  midi_sysex_pkg::wb_m2s_t rd_i,
    output midi_sysex_pkg::wb_s2m_t wr_o,
    output midi_sysex_pkg::wb_s2m_t rd_o
);
    import midi_sysex_pkg::*;

    localparam logic [7:0] BANK1_BASE = `MS_BANK_WORDS;
    localparam logic [7:0] BANK2_BASE = BANK1_BASE + `MS_BANK_WORDS;
    localparam logic [7:0] BANK5_BASE = BANK2_BASE + `MS_BANK_WORDS;

    logic [7:0] mem [`MS_PATCH_BYTES];
    logic       wr_req;
    logic       rd_req;
    logic [8:0] wr_map;     // {hit, flat index}
    logic [8:0] rd_map;

    function automatic logic [8:0] map_addr(input patch_addr_t adr);
        logic [7:0] off;
        off = {1'b0, adr.offset};
        case (adr.bank)
            3'd0:              map_addr = {off < `MS_BANK_WORDS, off};
            3'd1:              map_addr = {off < `MS_BANK_WORDS, off + BANK1_BASE};
            3'd2:              map_addr = {off < `MS_BANK_WORDS, off + BANK2_BASE};
            `MS_DUMP_BANK_3RD: map_addr = {off < `MS_LAST_BANK_WORDS, off + BANK5_BASE};
            default:           map_addr = 9'd0;
        endcase
    endfunction

    assign wr_map = map_addr(wr_i.adr);
    assign rd_map = map_addr(rd_i.adr);
    assign wr_req = wr_i.cyc && wr_i.stb && wr_i.we && !wr_o.ack;
    assign rd_req = rd_i.cyc && rd_i.stb && !rd_i.we && !rd_o.ack;

    always_ff @(posedge clk) begin
        if (!reset_reg_N) begin
            for (int i = 0; i < `MS_PATCH_BYTES; i++) begin
                mem[i] <= 8'h00;
            end
            wr_o.ack <= 1'b0;
            rd_o.ack <= 1'b0;
        end else begin
            wr_o.ack <= wr_i.cyc && wr_i.stb && !wr_o.ack;
            rd_o.ack <= rd_i.cyc && rd_i.stb && !rd_o.ack;
            if (wr_req) begin
                wr_o.dat <= wr_map[8] ? mem[wr_map[7:0]] : 8'h00;  // old value
                if (wr_map[8]) begin
                    mem[wr_map[7:0]] <= wr_i.dat;   // unmapped writes dropped
                end
            end
            if (rd_req) begin
                rd_o.dat <= rd_map[8] ? mem[rd_map[7:0]] : 8'h00;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!reset_reg_N)
        wr_o.ack |-> wr_i.cyc && wr_i.stb)
        else $error("write ack without strobe");
    assert property (@(posedge clk) disable iff (!reset_reg_N)
        rd_o.ack |-> rd_i.cyc && rd_i.stb)
        else $error("read ack without strobe");

endmodule

// File: src/patch_dump_tx.sv
`timescale 1ns/100ps
`include "midi_sysex_consts.svh"

module patch_dump_tx (
    input  logic                    clk,
    input  logic                    reset_reg_N,
    input  logic [3:0]              midi_channel,
    input  logic                    dump_req,
    input  midi_sysex_pkg::wb_s2m_t rd_i,
    input  logic                    tx_ready,
    output midi_sysex_pkg::wb_m2s_t rd_o,
    output logic [7:0]              tx_data,
    output logic                    tx_valid
);
    import midi_sysex_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_HEAD, S_FETCH, S_DATA, S_EOX} state_t;

    state_t      state;
    logic [1:0]  head_cnt;
    logic [7:0]  data_cnt;
    logic        rd_cyc;
    patch_addr_t rd_adr;
    patch_addr_t nxt_adr;
    logic [6:0]  last_off;
    logic        accept;

    assign accept   = tx_valid && tx_ready;
    assign last_off = (rd_adr.bank == `MS_DUMP_BANK_3RD) ? 7'(`MS_LAST_BANK_WORDS - 8'd1)
                                                         : 7'(`MS_BANK_WORDS - 8'd1);

    // bank walk 0, 1, 2, 5
    always_comb begin
        nxt_adr = rd_adr;
        if (rd_adr.offset == last_off) begin
            nxt_adr.offset = 7'd0;
            nxt_adr.bank   = (rd_adr.bank == 3'd2) ? `MS_DUMP_BANK_3RD : rd_adr.bank + 3'd1;
        end else begin
            nxt_adr.offset = rd_adr.offset + 7'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_reg_N) begin
            state    <= S_IDLE;
            tx_valid <= 1'b0;
            rd_cyc   <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (dump_req) begin     // requests while busy are dropped
                    tx_data  <= `MS_SOX;
                    tx_valid <= 1'b1;
                    head_cnt <= 2'd0;
                    data_cnt <= 8'd0;
                    rd_adr   <= '0;
                    state    <= S_HEAD;
                end
                S_HEAD: if (accept) begin
                    head_cnt <= head_cnt + 2'd1;
                    case (head_cnt)
                        2'd0: tx_data <= `MS_EDU_ID;
                        2'd1: tx_data <= {`MS_CMD_PATCH, midi_channel};
                        default: begin
                            tx_valid <= 1'b0;
                            rd_cyc   <= 1'b1;
                            state    <= S_FETCH;
                        end
                    endcase
                end
                S_FETCH: if (rd_i.ack) begin
                    rd_cyc   <= 1'b0;
                    tx_data  <= rd_i.dat;
                    tx_valid <= 1'b1;
                    state    <= S_DATA;
                end
                S_DATA: if (accept) begin
                    if (data_cnt == `MS_PATCH_BYTES - 8'd1) begin
                        tx_data <= `MS_EOX;
                        state   <= S_EOX;
                    end else begin
                        data_cnt <= data_cnt + 8'd1;
                        rd_adr   <= nxt_adr;
                        tx_valid <= 1'b0;
                        rd_cyc   <= 1'b1;
                        state    <= S_FETCH;
                    end
                end
                S_EOX: if (accept) begin
                    tx_valid <= 1'b0;
                    state    <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign rd_o = '{cyc: rd_cyc, stb: rd_cyc, we: 1'b0, adr: rd_adr, dat: 8'h00};

    assert property (@(posedge clk) disable iff (!reset_reg_N)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
        else $error("tx byte changed under back-pressure");

endmodule

// File: src/midi_sysex_top.sv
`timescale 1ns/100ps

module midi_sysex_top (
    input  logic       clk,
    input  logic       reset_reg_N,
    input  logic [3:0] midi_channel,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    input  logic       tx_ready,
    output logic [7:0] tx_data,
    output logic       tx_valid
);
    import midi_sysex_pkg::*;

    midi_byte_t rx_byte;
    logic       byte_stb;
    logic       dump_req;
    wb_m2s_t    wr_m2s;
    wb_s2m_t    wr_s2m;
    wb_m2s_t    rd_m2s;
    wb_s2m_t    rd_s2m;

    midi_byte_framer framer_i (
        .clk         (clk),
        .reset_reg_N (reset_reg_N),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .byte_out    (rx_byte),
        .byte_stb    (byte_stb)
    );

    sysex_decoder decoder_i (
        .clk          (clk),
        .reset_reg_N  (reset_reg_N),
        .midi_channel (midi_channel),
        .byte_in      (rx_byte),
        .byte_stb     (byte_stb),
        .wb_o         (wr_m2s),
        .wb_i         (wr_s2m),
        .dump_req     (dump_req)
    );

    patch_memory memory_i (
        .clk         (clk),
        .reset_reg_N (reset_reg_N),
        .wr_i        (wr_m2s),
        .rd_i        (rd_m2s),
        .wr_o        (wr_s2m),
        .rd_o        (rd_s2m)
    );

    patch_dump_tx dump_tx_i (
        .clk          (clk),
        .reset_reg_N  (reset_reg_N),
        .midi_channel (midi_channel),
        .dump_req     (dump_req),
        .rd_i         (rd_s2m),
        .tx_ready     (tx_ready),
        .rd_o         (rd_m2s),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid)
    );

endmodule

// File: testbench/tb_midi_sysex.sv
`timescale 1ns/100ps

module tb_midi_sysex;

    localparam logic [3:0] synth_ch = 4'd3;
    localparam int frame_len = 228;

    logic       clk;
    logic       reset_reg_N;
    logic [3:0] midi_channel;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       tx_ready;
    logic [7:0] tx_data;
    logic       tx_valid;

    logic [7:0] model [224];   // expected patch contents, flat dump order
    integer     seed;
    logic       rand_ready;
    int         byte_idx;
    int         frames_done;
    int         total_bytes;
    int         err_count;
    int         tests_passed;
    int         tests_failed;

    midi_sysex_top dut_i (
        .clk          (clk),
        .reset_reg_N  (reset_reg_N),
        .midi_channel (midi_channel),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .tx_ready     (tx_ready),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_eq(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            err_count++;
        end
    endtask

    // bank/offset to flat position, -1 when unmapped
    function automatic int flat_index(input int bank, input int off);
        if (bank <= 2 && off < 64) begin
            return bank * 64 + off;
        end else if (bank == 5 && off < 32) begin
            return 192 + off;
        end
        return -1;
    endfunction

    function automatic logic [7:0] exp_dump_byte(input int k);
        if (k == 0) begin
            return 8'hF0;
        end else if (k == 1) begin
            return 8'h7D;
        end else if (k == 2) begin
            return {4'h7, synth_ch};
        end else if (k == frame_len - 1) begin
            return 8'hF7;
        end
        return model[k - 3];
    endfunction

    task automatic model_write(input int bank, input int off, input logic [7:0] dat);
        int pos;
        pos = flat_index(bank, off);
        if (pos >= 0) begin
            model[pos] = dat;
        end
    endtask

    task automatic rand7(output logic [7:0] v);
        int r;
        r = $random(seed);
        v = {1'b0, r[6:0]};
    endtask

    // rising edge compare of every accepted tx byte
    always @(posedge clk) begin
        if (reset_reg_N && tx_valid && tx_ready) begin
            check_eq(int'(tx_data), int'(exp_dump_byte(byte_idx)),
                $sformatf("dump byte %0d", byte_idx));
            byte_idx++;
            total_bytes++;
            if (byte_idx == frame_len) begin
                byte_idx = 0;
                frames_done++;
            end
        end
    end

    always @(negedge clk) begin
        int r;
        if (rand_ready) begin
            r = $random(seed);
            tx_ready = r[0];
        end else begin
            tx_ready = 1'b1;
        end
    end

    task automatic send_byte(input logic [7:0] b);
        @(negedge clk);
        rx_data  = b;
        rx_valid = 1'b1;
        @(negedge clk);
        rx_valid = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    task automatic send_ctrl(input logic [3:0] ch, input logic [7:0] id, input logic [7:0] bank,
                             input logic [7:0] off, input logic [7:0] dat,
                             input logic [7:0] last);
        send_byte(8'hF0);
        send_byte(id);
        send_byte({4'h1, ch});
        send_byte(bank);
        send_byte(off);
        send_byte(dat);
        send_byte(last);
        if (last != 8'hF7) begin
            send_byte(8'hF7);
        end
    endtask

    task automatic wait_frames(input int target);
        int i;
        for (i = 0; i < 6000 && frames_done < target; i++) begin
            @(negedge clk);
        end
        if (frames_done < target) begin
            $display("timeout: dump frame did not complete within 6000 cycles");
            err_count++;
        end
    endtask

    task automatic request_dump();
        int start_frames;
        int start_bytes;
        start_frames = frames_done;
        start_bytes  = total_bytes;
        send_byte(8'hF0);
        send_byte(8'h7D);
        send_byte({4'h3, synth_ch});
        send_byte(8'hF7);
        wait_frames(start_frames + 1);
        @(negedge clk);
        check_eq(total_bytes - start_bytes, frame_len, "bytes in dump frame");
        check_eq(int'(tx_valid), 0, "tx_valid after end of frame");
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed", name);
            tests_failed++;
        end
    endtask

    initial begin
        int e0;
        int start_frames;
        int start_bytes;
        logic [7:0] d;

        reset_reg_N  = 1'b0;
        midi_channel = synth_ch;
        rx_data      = 8'h00;
        rx_valid     = 1'b0;
        tx_ready     = 1'b1;
        rand_ready   = 1'b0;
        seed         = 27220;
        byte_idx     = 0;
        frames_done  = 0;
        total_bytes  = 0;
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int i = 0; i < 224; i++) begin
            model[i] = 8'h00;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_reg_N = 1'b1;

        e0 = err_count;
        request_dump();
        end_test("dump after reset", e0);

        e0 = err_count;
        send_ctrl(synth_ch, 8'h7D, 8'd0, 8'd5, 8'h11, 8'hF7);
        model_write(0, 5, 8'h11);
        send_ctrl(synth_ch, 8'h7D, 8'd2, 8'd63, 8'h22, 8'hF7);
        model_write(2, 63, 8'h22);
        send_ctrl(synth_ch, 8'h7D, 8'd5, 8'd31, 8'h33, 8'hF7);
        model_write(5, 31, 8'h33);
        send_ctrl(synth_ch, 8'h7D, 8'd0, 8'd10, 8'h55, 8'h12);   // no F7 at index 6
        request_dump();
        end_test("control writes", e0);

        e0 = err_count;
        send_byte(8'hF0);
        send_byte(8'h7D);
        send_byte({4'h2, synth_ch});
        send_byte(8'd1);
        for (int i = 0; i < 40; i++) begin
            rand7(d);
            send_byte(d);
            model_write(1, i, d);
        end
        send_byte(8'hF7);
        request_dump();
        end_test("bank load", e0);

        e0 = err_count;
        send_byte(8'hF0);
        send_byte(8'h7D);
        send_byte({4'h7, synth_ch});
        for (int i = 0; i < 224; i++) begin
            rand7(d);
            send_byte(d);
            model[i] = d;
        end
        send_byte(8'hF7);
        request_dump();
        end_test("patch load", e0);

        e0 = err_count;
        send_ctrl(synth_ch ^ 4'd1, 8'h7D, 8'd0, 8'd0, 8'h7F, 8'hF7);
        send_ctrl(synth_ch, 8'h7E, 8'd0, 8'd1, 8'h7E, 8'hF7);
        send_ctrl(synth_ch, 8'h7D, 8'd0, 8'd2, 8'h90, 8'h66);    // status byte aborts at index 5
        send_byte(8'hF0);
        send_byte(8'hF8);
        send_byte(8'h7D);
        send_byte({4'h2, synth_ch});
        send_byte(8'hF8);
        send_byte(8'd2);
        for (int i = 0; i < 8; i++) begin
            rand7(d);
            send_byte(d);
            send_byte(8'hF8);
            model_write(2, i, d);
        end
        send_byte(8'hF7);
        request_dump();
        end_test("ignored frames and realtime bytes", e0);

        e0 = err_count;
        start_frames = frames_done;
        start_bytes  = total_bytes;
        rand_ready   = 1'b1;
        for (int n = 0; n < 2; n++) begin
            send_byte(8'hF0);
            send_byte(8'h7D);
            send_byte({4'h3, synth_ch});
            send_byte(8'hF7);
        end
        wait_frames(start_frames + 1);
        repeat (400) @(negedge clk);   // room for a second frame, if any
        rand_ready = 1'b0;
        check_eq(frames_done - start_frames, 1, "frames for two requests");
        check_eq(total_bytes - start_bytes, frame_len, "bytes for two requests");
        check_eq(byte_idx, 0, "partial frame after dump");
        end_test("back-pressure and repeated request", e0);

        $display("tests passed %0d, tests failed %0d, check errors %0d",
            tests_passed, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: midi_sysex.f
+incdir+include
src/midi_sysex_pkg.sv
src/midi_byte_framer.sv
src/sysex_decoder.sv
src/patch_memory.sv
src/patch_dump_tx.sv
src/midi_sysex_top.sv
testbench/tb_midi_sysex.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the MIDI sysex testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f midi_sysex.f --top-module tb_midi_sysex \
    -Mdir obj_dir -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "compile failed, see build.log"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
